//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_checkpoint_unit
FILELIST  ?= checkpoint_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# Build and run, then pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- checkpoint_unit.f
chk_cfg_pkg.sv
chk_types_pkg.sv
chk_if.sv
chk_find_chain.sv
chk_release_port.sv
chk_bitmap_alloc.sv
checkpoint_unit.sv
tb_clock_gen.sv
tb_checkpoint_unit.sv

//--- checkpoint_unit.sv
// Branch checkpoint unit top level
module checkpoint_unit
	import chk_types_pkg::*;
(
	input  logic       clk5x,
	input  logic       rst,

	// Allocation from decode
	input  logic       alloc_req,
	input  br_mask_t   alloc_br,
	output logic       alloc_ack,
	output chk_group_t alloc_chkptn,

	// First release source
	input  logic       rel_a_req,
	input  chk_ndx_t   rel_a_ndx,
	output logic       rel_a_ack,

	// Second release source
	input  logic       rel_b_req,
	input  chk_ndx_t   rel_b_ndx,
	output logic       rel_b_ack,

	output logic       stall,
	output chk_cnt_t   free_count
);

	// ==================================================
	// Internal buses
	// ==================================================

	chk_alloc_if alloc_bus ();
	chk_rel_if   rel_a_bus ();
	chk_rel_if   rel_b_bus ();

	// Plain ports stand in for the requester and source sides
	assign alloc_bus.req = alloc_req;
	assign alloc_bus.br  = alloc_br;
	assign alloc_ack     = alloc_bus.ack;
	assign alloc_chkptn  = alloc_bus.chkptn;

	assign rel_a_bus.req = rel_a_req;
	assign rel_a_bus.ndx = rel_a_ndx;
	assign rel_a_ack     = rel_a_bus.ack;

	assign rel_b_bus.req = rel_b_req;
	assign rel_b_bus.ndx = rel_b_ndx;
	assign rel_b_ack     = rel_b_bus.ack;

	// ==================================================
	// Release receivers and allocator
	// ==================================================

	chk_release_port rel_a_port_inst (
		.clk5x (clk5x),
		.rst   (rst),
		.rel   (rel_a_bus.port)
	);

	chk_release_port rel_b_port_inst (
		.clk5x (clk5x),
		.rst   (rst),
		.rel   (rel_b_bus.port)
	);

	chk_bitmap_alloc bitmap_alloc_inst (
		.clk5x      (clk5x),
		.rst        (rst),
		.alloc      (alloc_bus.allocator),
		.rel_a      (rel_a_bus.sink),
		.rel_b      (rel_b_bus.sink),
		.stall      (stall),
		.free_count (free_count)
	);

endmodule

//--- chk_bitmap_alloc.sv
// Checkpoint bitmap and group allocator
module chk_bitmap_alloc
	import chk_cfg_pkg::*;
	import chk_types_pkg::*;
(
	input  logic           clk5x,
	input  logic           rst,
	chk_alloc_if.allocator alloc,
	chk_rel_if.sink        rel_a,
	chk_rel_if.sink        rel_b,
	output logic           stall,
	output chk_cnt_t       free_count
);

	// Free bitmap, one bit per checkpoint
	chk_map_t map;
	chk_map_t map_next;

	// Candidates from the finder chain, lowest free index first
	chk_group_t cand;
	br_mask_t   found;

	// Group as it would be registered on a grant
	chk_group_t grp_next;

	logic room;
	logic take;
	logic grant;
	logic rel_a_ok;
	logic rel_b_ok;

	chk_find_chain find_chain_inst (
		.map   (map),
		.ndx   (cand),
		.found (found)
	);

	// ==================================================
	// Group compaction
	// ==================================================

	// The k-th branch slot in ascending order takes the k-th candidate
	// room drops when some branch slot has no candidate left, which is the same
	// as free_count being below the number of branches in the group
	always_comb begin : compact
		int unsigned k;
		k    = 0;
		room = 1'b1;
		for (int s = 0; s < NSLOT; s++) begin
			grp_next[s] = chk_ndx_t'(RSV_CHK);
			if (alloc.br[s]) begin
				grp_next[s] = cand[k];
				room        = room & found[k];
				k++;
			end
		end
	end

	// A pending request is one that has not been acknowledged yet
	assign take  = alloc.req && !alloc.ack;
	assign grant = take && room;

	// Raised for as long as a pending group waits for checkpoints
	assign stall = take && !room;

	// A release of the reserved slot or of a bit already free is dropped
	// This also keeps a release from landing on a bit being allocated now
	assign rel_a_ok = rel_a.free && (rel_a.free_ndx != chk_ndx_t'(RSV_CHK))
		&& !map[rel_a.free_ndx];
	assign rel_b_ok = rel_b.free && (rel_b.free_ndx != chk_ndx_t'(RSV_CHK))
		&& !map[rel_b.free_ndx];

	// ==================================================
	// Bitmap update
	// ==================================================

	// Allocation and both releases all apply in the same cycle
	// Finders look at the current map, so a freed bit is offered next cycle
	always_comb begin
		map_next = map;
		if (grant) begin
			for (int s = 0; s < NSLOT; s++) begin
				if (alloc.br[s]) begin
					map_next[grp_next[s]] = 1'b0;
				end
			end
		end
		if (rel_a_ok) begin
			map_next[rel_a.free_ndx] = 1'b1;
		end
		if (rel_b_ok) begin
			map_next[rel_b.free_ndx] = 1'b1;
		end
	end

	always_ff @(posedge clk5x) begin
		if (rst) begin
			// Everything free except the architectural checkpoint
			map <= ~(chk_map_t'(1) << RSV_CHK);
		end else begin
			map <= map_next;
		end
	end

	// ==================================================
	// Allocation handshake
	// ==================================================

	always_ff @(posedge clk5x) begin
		if (rst) begin
			alloc.ack    <= 1'b0;
			alloc.chkptn <= {NSLOT{chk_ndx_t'(RSV_CHK)}};
		end else if (grant) begin
			alloc.ack    <= 1'b1;
			alloc.chkptn <= grp_next;
		end else if (alloc.ack && !alloc.req) begin
			// Requester has let go, close the handshake
			alloc.ack <= 1'b0;
		end
	end

	// Population of the bitmap
	always_comb begin
		free_count = '0;
		for (int b = 0; b < NCHECK; b++) begin
			free_count = free_count + chk_cnt_t'(map[b]);
		end
	end

endmodule

//--- chk_cfg_pkg.sv
// Checkpoint unit sizing
package chk_cfg_pkg;

	// ==================================================
	// Checkpoint pool
	// ==================================================

	// Total number of branch checkpoints in the pool
	localparam int NCHECK = 16;

	// Bits needed to name one checkpoint
	localparam int CHK_W = $clog2(NCHECK);

	// The free count must reach NCHECK itself, hence one extra bit
	localparam int CNT_W = $clog2(NCHECK) + 1;

	// Checkpoint 0 stands for the architectural state and is never handed out
	localparam int RSV_CHK = 0;

	// ==================================================
	// Decode group
	// ==================================================

	// Instruction slots presented by decode in one group
	localparam int NSLOT = 4;

endpackage

//--- chk_find_chain.sv
// Cascaded lowest free finders
module chk_find_chain
	import chk_cfg_pkg::*;
	import chk_types_pkg::*;
(
	input  chk_map_t   map,
	output chk_group_t ndx,
	output br_mask_t   found
);

	// Position of the lowest set bit or zero when nothing is set
	// Scanning from the top lets the lowest hit win the last assignment
	function automatic chk_ndx_t lowest_set(input chk_map_t m);
		chk_ndx_t pos;
		pos = '0;
		for (int b = NCHECK - 1; b >= 0; b--) begin
			if (m[b]) begin
				pos = chk_ndx_t'(b);
			end
		end
		return pos;
	endfunction

	// Map seen by each stage
	// Stage 0 sees the full bitmap and each later stage sees one bit fewer
	chk_map_t stage_map [NSLOT];

	assign stage_map[0] = map;

	// ==================================================
	// One finder per slot
	// ==================================================

	for (genvar g = 0; g < NSLOT; g++) begin : g_stage

		// Any bit left means this stage has a checkpoint to offer
		assign found[g] = |stage_map[g];

		assign ndx[g] = lowest_set(stage_map[g]);

		// Clearing the lowest set bit hands the rest to the next stage
		// An empty map stays empty, so stages past the last free bit find nothing
		if (g < NSLOT - 1) begin : g_next
			assign stage_map[g+1] = stage_map[g] & (stage_map[g] - chk_map_t'(1));
		end

	end

endmodule

//--- chk_if.sv
// Checkpoint allocation and release buses

// ==================================================
// Allocation bus between decode and the allocator
// ==================================================

// Four-phase req/ack
// The requester holds req and br until ack, then drops req
// ack falls once req is seen low, and a new req waits for ack low
interface chk_alloc_if import chk_types_pkg::*; ();

	logic       req;
	br_mask_t   br;
	logic       ack;
	chk_group_t chkptn;

	modport requester (output req, output br, input ack, input chkptn);
	modport allocator (input req, input br, output ack, output chkptn);

endinterface

// ==================================================
// Release bus from one branch resolve source
// ==================================================

// Source side follows the same four-phase rule as allocation
// The port side turns each handshake into one free pulse for the bitmap
interface chk_rel_if import chk_types_pkg::*; ();

	logic     req;
	chk_ndx_t ndx;
	logic     ack;
	logic     free;
	chk_ndx_t free_ndx;

	modport source (output req, output ndx, input ack);
	modport port (input req, input ndx, output ack, output free, output free_ndx);
	modport sink (input free, input free_ndx);

endinterface

//--- chk_release_port.sv
// Four-phase checkpoint release receiver
module chk_release_port (
	input logic     clk5x,
	input logic     rst,
	chk_rel_if.port rel
);

	// A new handshake opens when req is seen high while ack is still low
	// Holding ack high until req drops keeps a held req from pulsing twice
	logic take;

	assign take = rel.req && !rel.ack;

	// ==================================================
	// Handshake state and free pulse
	// ==================================================

	always_ff @(posedge clk5x) begin
		if (rst) begin
			rel.ack  <= 1'b0;
			rel.free <= 1'b0;
		end else begin
			// Exactly one cycle of free per handshake, in step with the rise of ack
			rel.free <= take;

			if (take) begin
				rel.ack <= 1'b1;
			end else if (rel.ack && !rel.req) begin
				// Source has dropped req, so close the handshake
				rel.ack <= 1'b0;
			end
		end
	end

	// ==================================================
	// Released index
	// ==================================================

	// Captured with the opening edge so it is valid while free is high
	// The bitmap picks it up at the edge that ends the free pulse
	always_ff @(posedge clk5x) begin
		if (take) begin
			rel.free_ndx <= rel.ndx;
		end
	end

endmodule

//--- chk_types_pkg.sv
// Checkpoint unit shared types
package chk_types_pkg;

	import chk_cfg_pkg::*;

	// Index of one checkpoint in the pool
	typedef logic [CHK_W-1:0] chk_ndx_t;

	// Free bitmap over the whole pool
	// A set bit means the checkpoint is free to be allocated
	typedef logic [NCHECK-1:0] chk_map_t;

	// One bit per decode slot, set when that slot holds a branch
	typedef logic [NSLOT-1:0] br_mask_t;

	// Indices handed to the slots of one group
	// Entry s belongs to slot s, non-branch slots carry RSV_CHK
	typedef chk_ndx_t [NSLOT-1:0] chk_group_t;

	// Number of free checkpoints, 0 up to NCHECK
	typedef logic [CNT_W-1:0] chk_cnt_t;

endpackage

//--- tb_checkpoint_unit.sv
// Checkpoint unit testbench
module tb_checkpoint_unit
	import chk_cfg_pkg::*;
	import chk_types_pkg::*;
();

	localparam int WAIT_LIMIT = 50;
	localparam int K_ALLOC = 0;
	localparam int K_REL_A = 1;
	localparam int K_REL_B = 2;
	localparam int K_REL_AB = 3;
	localparam int K_REL_RAND = 4;

	logic       clk5x;
	logic       rst;
	logic       alloc_req;
	br_mask_t   alloc_br;
	logic       alloc_ack;
	chk_group_t alloc_chkptn;
	logic       rel_a_req;
	chk_ndx_t   rel_a_ndx;
	logic       rel_a_ack;
	logic       rel_b_req;
	chk_ndx_t   rel_b_ndx;
	logic       rel_b_ack;
	logic       stall;
	chk_cnt_t   free_count;

	// Step table held as one queue per column and filled in order
	string      step_name[$];
	int         step_kind[$];
	logic [3:0] step_arg_a[$];
	logic [3:0] step_arg_b[$];
	logic       step_stall[$];

	// Reference bitmap where a set bit marks a free checkpoint
	chk_map_t ref_map;

	// A group that stalled stays open until releases make room for it
	logic     pending;
	br_mask_t pending_mask;
	string    pending_name;
	int       mismatches;
	int       timeouts;

	tb_clock_gen clock_gen_inst (.clk5x(clk5x), .rst(rst));

	checkpoint_unit checkpoint_unit_inst (
		.clk5x (clk5x), .rst (rst),
		.alloc_req (alloc_req), .alloc_br (alloc_br),
		.alloc_ack (alloc_ack), .alloc_chkptn (alloc_chkptn),
		.rel_a_req (rel_a_req), .rel_a_ndx (rel_a_ndx), .rel_a_ack (rel_a_ack),
		.rel_b_req (rel_b_req), .rel_b_ndx (rel_b_ndx), .rel_b_ack (rel_b_ack),
		.stall (stall), .free_count (free_count)
	);

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_group(input string name, input chk_group_t exp, input chk_group_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_count(input string name, input chk_cnt_t exp, input chk_cnt_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			mismatches++;
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// Branch slots in ascending order take free indices in ascending order
	function automatic chk_group_t take_group(input br_mask_t mask);
		chk_group_t grp;
		int b;
		b = 0;
		for (int s = 0; s < NSLOT; s++) begin
			grp[s] = chk_ndx_t'(RSV_CHK);
			if (mask[s]) begin
				while (b < NCHECK && !ref_map[chk_ndx_t'(b)]) begin
					b++;
				end
				if (b < NCHECK) begin
					grp[s] = chk_ndx_t'(b);
					ref_map[chk_ndx_t'(b)] = 1'b0;
				end
			end
		end
		return grp;
	endfunction

	// A group is granted only when every branch in it can be served
	function automatic logic room_for(input br_mask_t mask);
		return $countones(ref_map) >= $countones(mask);
	endfunction

	// Releasing the reserved checkpoint is ignored and a free one stays free
	function automatic void release_ref(input chk_ndx_t ndx);
		if (ndx != chk_ndx_t'(RSV_CHK)) begin
			ref_map[ndx] = 1'b1;
		end
	endfunction

	function automatic logic ack_of(input int which);
		case (which)
			0: return alloc_ack;
			1: return rel_a_ack;
			default: return rel_b_ack;
		endcase
	endfunction

	// ==================================================
	// Handshake tasks
	// ==================================================

	// Acks are sampled on the falling edge away from the driving edge
	task automatic wait_ack(input string name, input int which, input logic level);
		int n;
		n = 0;
		@(negedge clk5x);
		while (ack_of(which) !== level && n < WAIT_LIMIT) begin
			@(negedge clk5x);
			n++;
		end
		if (ack_of(which) !== level) begin
			$display("Timeout in %s: ack %0d never went to %b", name, which, level);
			timeouts++;
		end
	endtask

	task automatic finish_alloc(input string name, input chk_group_t exp);
		wait_ack(name, 0, 1'b1);
		check_group({name, " chkptn"}, exp, alloc_chkptn);
		@(posedge clk5x);
		alloc_req <= 1'b0;
		// The allocator still saw req high on the edge that dropped it
		@(negedge clk5x);
		check_bit({name, " ack until req low"}, 1'b1, alloc_ack);
		wait_ack(name, 0, 1'b0);
		// Without a new req the ack has to stay down
		@(negedge clk5x);
		check_bit({name, " ack stays low"}, 1'b0, alloc_ack);
		check_bit({name, " stall after"}, 1'b0, stall);
	endtask

	task automatic run_alloc(input string name, input br_mask_t mask, input logic exp_stall);
		@(posedge clk5x);
		alloc_req <= 1'b1;
		alloc_br  <= mask;
		@(negedge clk5x);
		check_bit({name, " stall"}, exp_stall, stall);
		if (exp_stall) begin
			repeat (3) begin
				@(negedge clk5x);
				check_bit({name, " ack held"}, 1'b0, alloc_ack);
				check_bit({name, " stall held"}, 1'b1, stall);
			end
			pending      = 1'b1;
			pending_mask = mask;
			pending_name = name;
		end else begin
			finish_alloc(name, take_group(mask));
		end
	endtask

	task automatic run_release(input string name, input logic use_a, input logic use_b,
		input chk_ndx_t ndx_a, input chk_ndx_t ndx_b);
		@(posedge clk5x);
		rel_a_req <= use_a;
		rel_a_ndx <= ndx_a;
		rel_b_req <= use_b;
		rel_b_ndx <= ndx_b;
		if (use_a) wait_ack(name, 1, 1'b1);
		if (use_b) wait_ack(name, 2, 1'b1);
		@(posedge clk5x);
		rel_a_req <= 1'b0;
		rel_b_req <= 1'b0;
		// Each port still saw req high on the edge that dropped it
		@(negedge clk5x);
		if (use_a) check_bit({name, " rel_a_ack until req low"}, 1'b1, rel_a_ack);
		if (use_b) check_bit({name, " rel_b_ack until req low"}, 1'b1, rel_b_ack);
		if (use_a) wait_ack(name, 1, 1'b0);
		if (use_b) wait_ack(name, 2, 1'b0);
		@(negedge clk5x);
		check_bit({name, " rel_a_ack stays low"}, 1'b0, rel_a_ack);
		check_bit({name, " rel_b_ack stays low"}, 1'b0, rel_b_ack);
		if (use_a) release_ref(ndx_a);
		if (use_b) release_ref(ndx_b);
	endtask

	task automatic add_step(input string name, input int kind, input logic [3:0] arg_a,
		input logic [3:0] arg_b, input logic exp_stall);
		step_name.push_back(name);
		step_kind.push_back(kind);
		step_arg_a.push_back(arg_a);
		step_arg_b.push_back(arg_b);
		step_stall.push_back(exp_stall);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		int unsigned port;
		logic [3:0]  tmp;
		int          n;
		chk_group_t  rsv_group;
		alloc_req = 1'b0;
		alloc_br  = '0;
		rel_a_req = 1'b0;
		rel_a_ndx = '0;
		rel_b_req = 1'b0;
		rel_b_ndx = '0;
		pending    = 1'b0;
		mismatches = 0;
		timeouts   = 0;
		ref_map    = ~(chk_map_t'(1) << RSV_CHK);
		void'($urandom(22));

		// Fill the pool, stall on a short pool, then release and reuse
		add_step("alloc_full", K_ALLOC, 4'b1111, 4'd0, 1'b0);
		add_step("alloc_sparse", K_ALLOC, 4'b1010, 4'd0, 1'b0);
		add_step("alloc_fill_a", K_ALLOC, 4'b1111, 4'd0, 1'b0);
		add_step("alloc_fill_b", K_ALLOC, 4'b0111, 4'd0, 1'b0);
		add_step("alloc_short", K_ALLOC, 4'b0111, 4'd0, 1'b1);
		add_step("rel_a_unblock", K_REL_A, 4'd3, 4'd0, 1'b0);
		add_step("rel_b_single", K_REL_B, 4'd9, 4'd0, 1'b0);
		add_step("alloc_reuse", K_ALLOC, 4'b0001, 4'd0, 1'b0);
		add_step("rel_both", K_REL_AB, 4'd2, 4'd12, 1'b0);
		add_step("rel_reserved", K_REL_A, 4'd0, 4'd0, 1'b0);
		add_step("rel_already_free", K_REL_B, 4'd2, 4'd0, 1'b0);
		add_step("alloc_after_both", K_ALLOC, 4'b0011, 4'd0, 1'b0);
		add_step("rel_rand_first", K_REL_RAND, 4'd5, 4'd0, 1'b0);
		add_step("rel_rand_second", K_REL_RAND, 4'd6, 4'd0, 1'b0);
		add_step("alloc_upper", K_ALLOC, 4'b1100, 4'd0, 1'b0);

		// Random order of the last two releases
		if ($urandom % 2 == 1) begin
			tmp           = step_arg_a[12];
			step_arg_a[12] = step_arg_a[13];
			step_arg_a[13] = tmp;
		end

		// Reset may still be unknown at time zero
		n = 0;
		while (rst !== 1'b0 && n < WAIT_LIMIT) begin
			@(posedge clk5x);
			n++;
		end
		if (rst !== 1'b0) begin
			$display("Timeout: reset never went low");
			timeouts++;
		end

		// State right after reset
		for (int s = 0; s < NSLOT; s++) begin
			rsv_group[s] = chk_ndx_t'(RSV_CHK);
		end
		@(negedge clk5x);
		check_count("reset free_count", chk_cnt_t'($countones(ref_map)), free_count);
		check_bit("reset stall", 1'b0, stall);
		check_bit("reset alloc_ack", 1'b0, alloc_ack);
		check_bit("reset rel_a_ack", 1'b0, rel_a_ack);
		check_bit("reset rel_b_ack", 1'b0, rel_b_ack);
		check_group("reset chkptn", rsv_group, alloc_chkptn);

		for (int i = 0; i < step_name.size(); i++) begin
			case (step_kind[i])
				K_ALLOC: run_alloc(step_name[i], br_mask_t'(step_arg_a[i]), step_stall[i]);
				K_REL_A: run_release(step_name[i], 1'b1, 1'b0, step_arg_a[i], '0);
				K_REL_B: run_release(step_name[i], 1'b0, 1'b1, '0, step_arg_a[i]);
				K_REL_AB: run_release(step_name[i], 1'b1, 1'b1, step_arg_a[i], step_arg_b[i]);
				default: begin
					port = $urandom % 2;
					run_release(step_name[i], port == 0, port == 1, step_arg_a[i], step_arg_a[i]);
				end
			endcase
			// A stalled group completes once the model has room for it
			if (pending && room_for(pending_mask)) begin
				pending = 1'b0;
				finish_alloc(pending_name, take_group(pending_mask));
			end else if (pending) begin
				check_bit({step_name[i], " still stalled"}, 1'b1, stall);
			end
			@(negedge clk5x);
			check_count({step_name[i], " free_count"}, chk_cnt_t'($countones(ref_map)),
				free_count);
		end

		if (pending) begin
			$display("Group %s never completed", pending_name);
			timeouts++;
		end
		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset
module tb_clock_gen (
	output logic clk5x,
	output logic rst
);

	// Free running clock with a period of 10
	initial begin
		clk5x = 1'b0;
		forever begin
			#5 clk5x = ~clk5x;
		end
	end

	// Reset is held for the first 16 rising edges and released on an edge
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk5x);
		rst <= 1'b0;
	end

endmodule
